// File: rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  typedef enum logic [1:0] {
    mem_none,
    mem_load,
    mem_store
  } mem_op_e;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } mem_size_e;

  // Source of the register file write data.
  typedef enum logic [1:0] {
    wd_alu,
    wd_mem,
    wd_pc_plus4,
    wd_src2
  } wd_sel_e;

  typedef enum logic {
    csr_wd_alu,
    csr_wd_pc
  } csr_wd_sel_e;

  // Request from execute. addr is the ALU result, also for pass-through.
  typedef struct packed {
    mem_op_e           op;
    mem_size_e         size;
    logic              load_signed;
    logic [xlen-1:0]   addr;
    logic [xlen-1:0]   store_data;
    logic [xlen-1:0]   src2;
    logic [xlen-1:0]   pc;
    logic [4:0]        rd;
    logic              reg_we;
    logic              csr_we;
    wd_sel_e           wd_sel;
    csr_wd_sel_e       csr_wd_sel;
  } lsu_req_t;

  typedef struct packed {
    logic [xlen-1:0]   wd;
    logic [xlen-1:0]   csr_wd;
    logic [4:0]        rd;
    logic              reg_we;
    logic              csr_we;
    logic [xlen-1:0]   pc;
    logic              access_fault;
  } lsu_wb_t;

endpackage

// File: axi_pkg.sv
package axi_pkg;

  localparam int axi_addr_w = 32;

  // One strobe bit per byte lane of the 32-bit data bus.
  localparam int axi_strb_w = 4;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: axi_lite_if.sv
`timescale 1ns/100ps

interface axi_lite_if;
  import axi_pkg::*;

  // Read address and read data channels.
  logic [axi_addr_w-1:0]     araddr;
  logic                      arvalid;
  logic                      arready;
  logic [axi_strb_w*8-1:0]   rdata;
  logic [1:0]                rresp;
  logic                      rvalid;
  logic                      rready;

  // Write address, write data and write response channels.
  logic [axi_addr_w-1:0]     awaddr;
  logic                      awvalid;
  logic                      awready;
  logic [axi_strb_w*8-1:0]   wdata;
  logic [axi_strb_w-1:0]     wstrb;
  logic                      wvalid;
  logic                      wready;
  logic [1:0]                bresp;
  logic                      bvalid;
  logic                      bready;

  modport master (
    output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slave (
    input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

endinterface

// File: mem_align.sv
`timescale 1ns/100ps

module mem_align (
  input  rv_pkg::mem_size_e         size,
  input  logic [1:0]                addr_lo,
  input  logic                      load_signed,
  input  logic [rv_pkg::xlen-1:0]   store_data,
  input  logic [rv_pkg::xlen-1:0]   rdata,
  output logic [rv_pkg::xlen-1:0]   wdata,
  output logic [3:0]                wstrb,
  output logic [rv_pkg::xlen-1:0]   load_value
);
  import rv_pkg::*;

  logic [xlen-1:0] rdata_shifted;

  // **************************************************
  // Store side
  // **************************************************

  // The narrow value is copied to every lane, the strobe picks the lanes.
  always_comb begin
    case (size)
      size_byte: begin
        wdata = {4{store_data[7:0]}};
        wstrb = 4'b0001 << addr_lo;
      end
      size_half: begin
        wdata = {2{store_data[15:0]}};
        wstrb = 4'b0011 << {addr_lo[1], 1'b0};
      end
      default: begin
        wdata = store_data;
        wstrb = 4'b1111;
      end
    endcase
  end

  // **************************************************
  // Load side
  // **************************************************

  assign rdata_shifted = rdata >> {addr_lo, 3'b000};

  always_comb begin
    case (size)
      size_byte: begin
        load_value = {{24{load_signed & rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      size_half: begin
        load_value = {{16{load_signed & rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      default: begin
        load_value = rdata;
      end
    endcase
  end

  // Halfword and word accesses must be naturally aligned.
  always_comb begin
    if (!$isunknown({size, addr_lo})) begin
      assert final (!((size == size_half && addr_lo[0]) ||
                      (size == size_word && addr_lo != 2'b00)))
        else $error("mem_align: misaligned access, size %s addr_lo %b",
                    size.name(), addr_lo);
    end
  end

endmodule

// File: lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  input  rv_pkg::lsu_req_t                req,
  input  logic                            req_valid,
  output logic                            req_ready,
  output rv_pkg::lsu_wb_t                 wb,
  output logic                            wb_valid,
  input  logic                            wb_ready,
  axi_lite_if.master                      axi,
  input  logic [rv_pkg::xlen-1:0]         st_data,
  input  logic [axi_pkg::axi_strb_w-1:0]  st_strb,
  input  logic [rv_pkg::xlen-1:0]         ld_value,
  output rv_pkg::mem_size_e               cap_size,
  output logic [1:0]                      cap_addr_lo,
  output logic                            cap_load_signed,
  output logic [rv_pkg::xlen-1:0]         cap_store_data,
  output logic [rv_pkg::xlen-1:0]         rdata_q
);
  import rv_pkg::*;
  import axi_pkg::*;

  typedef enum logic [2:0] {
    idle,
    read_addr,
    read_data,
    write_req,
    write_resp,
    done
  } state_e;

  state_e    state;
  state_e    state_nxt;
  lsu_req_t  cap;
  logic      fault;
  logic      aw_done;
  logic      w_done;
  logic      accept;
  logic      ar_fire;
  logic      r_fire;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;

  assign accept  = req_valid && req_ready;
  assign ar_fire = axi.arvalid && axi.arready;
  assign r_fire  = axi.rvalid && axi.rready;
  assign aw_fire = axi.awvalid && axi.awready;
  assign w_fire  = axi.wvalid && axi.wready;
  assign b_fire  = axi.bvalid && axi.bready;

  // **************************************************
  // State machine
  // **************************************************

  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (req_valid) begin
          case (req.op)
            mem_load:  state_nxt = read_addr;
            mem_store: state_nxt = write_req;
            default:   state_nxt = done;
          endcase
        end
      end
      read_addr:  if (ar_fire) state_nxt = read_data;
      read_data:  if (r_fire) state_nxt = done;
      write_req: begin
        if ((aw_done || aw_fire) && (w_done || w_fire)) begin
          state_nxt = write_resp;
        end
      end
      write_resp: if (b_fire) state_nxt = done;
      done:       if (wb_ready) state_nxt = idle;
      default:    state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  // AW and W may complete in different cycles, so each is tracked.
  always_ff @(posedge clk) begin
    if (rst || state != write_req) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (aw_fire) aw_done <= 1'b1;
      if (w_fire) w_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      axi.rready <= 1'b0;
      axi.bready <= 1'b0;
    end else begin
      axi.rready <= 1'b1;
      axi.bready <= 1'b1;
    end
  end

  // Request capture and completion status.
  always_ff @(posedge clk) begin
    if (accept) begin
      cap   <= req;
      fault <= 1'b0;
    end
    if (r_fire) begin
      rdata_q <= axi.rdata;
      fault   <= (axi.rresp != resp_okay);
    end
    if (b_fire) begin
      fault <= (axi.bresp != resp_okay);
    end
  end

  // **************************************************
  // AXI master channels and aligner hookup
  // **************************************************

  assign axi.araddr  = cap.addr;
  assign axi.arvalid = (state == read_addr);
  assign axi.awaddr  = cap.addr;
  assign axi.awvalid = (state == write_req) && !aw_done;
  assign axi.wdata   = st_data;
  assign axi.wstrb   = st_strb;
  assign axi.wvalid  = (state == write_req) && !w_done;

  // A pass-through has no access size, so it is shown to the aligner as a byte.
  assign cap_size        = (cap.op == mem_none) ? size_byte : cap.size;
  assign cap_addr_lo     = cap.addr[1:0];
  assign cap_load_signed = cap.load_signed;
  assign cap_store_data  = cap.store_data;

  // **************************************************
  // Writeback bundle
  // **************************************************

  always_comb begin
    case (cap.wd_sel)
      wd_alu:      wb.wd = cap.addr;
      wd_mem:      wb.wd = ld_value;
      wd_pc_plus4: wb.wd = cap.pc + 32'd4;
      default:     wb.wd = cap.src2;
    endcase
    wb.csr_wd       = (cap.csr_wd_sel == csr_wd_pc) ? cap.pc : cap.addr;
    wb.rd           = cap.rd;
    wb.reg_we       = cap.reg_we && !fault;
    wb.csr_we       = cap.csr_we && !fault;
    wb.pc           = cap.pc;
    wb.access_fault = fault;
  end

  assign req_ready = (state == idle);
  assign wb_valid  = (state == done);

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    axi.arvalid && !axi.arready |=> axi.arvalid && $stable(axi.araddr));

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    axi.awvalid && !axi.awready |=> axi.awvalid && $stable(axi.awaddr));

  wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb));

endmodule

// File: axi_lite_ram.sv
`timescale 1ns/100ps

module axi_lite_ram #(
  parameter int mem_words  = 256,
  parameter int rd_latency = 2
) (
  input  logic       clk,
  input  logic       rst,
  axi_lite_if.slave  bus
);
  import axi_pkg::*;

  localparam int idx_w = $clog2(mem_words);

  if (rd_latency < 1 || rd_latency > 8) begin : g_bad_latency
    $error("axi_lite_ram: rd_latency %0d is outside 1 to 8", rd_latency);
  end

  logic [axi_strb_w*8-1:0]  mem [mem_words];
  logic                     rd_pending;
  logic [3:0]               rd_cnt;
  logic [axi_strb_w*8-1:0]  rd_data_q;
  logic                     rd_err_q;
  logic                     rd_in_range;
  logic                     wr_in_range;
  logic                     wr_fire;

  assign rd_in_range = (bus.araddr[axi_addr_w-1:2] < mem_words);
  assign wr_in_range = (bus.awaddr[axi_addr_w-1:2] < mem_words);

  // **************************************************
  // Read path
  // **************************************************

  // The word is sampled at the AR transfer and shown after rd_latency cycles.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
      rd_cnt     <= '0;
    end else if (bus.arvalid && bus.arready) begin
      rd_pending <= 1'b1;
      rd_cnt     <= 4'(rd_latency - 1);
    end else if (bus.rvalid && bus.rready) begin
      rd_pending <= 1'b0;
    end else if (rd_pending && rd_cnt != 0) begin
      rd_cnt <= rd_cnt - 4'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.arvalid && bus.arready) begin
      rd_data_q <= rd_in_range ? mem[bus.araddr[idx_w+1:2]] : '0;
      rd_err_q  <= !rd_in_range;
    end
  end

  assign bus.arready = !rd_pending;
  assign bus.rvalid  = rd_pending && (rd_cnt == 0);
  assign bus.rdata   = rd_data_q;
  assign bus.rresp   = rd_err_q ? resp_slverr : resp_okay;

  // **************************************************
  // Write path
  // **************************************************

  assign wr_fire     = bus.awvalid && bus.wvalid && !bus.bvalid;
  assign bus.awready = wr_fire;
  assign bus.wready  = wr_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.bvalid <= 1'b0;
    end else if (wr_fire) begin
      bus.bvalid <= 1'b1;
    end else if (bus.bready) begin
      bus.bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bus.bresp <= wr_in_range ? resp_okay : resp_slverr;
      if (wr_in_range) begin
        for (int i = 0; i < axi_strb_w; i++) begin
          if (bus.wstrb[i]) mem[bus.awaddr[idx_w+1:2]][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  // The master must not start a second read before R completes.
  ar_single: assert property (@(posedge clk) disable iff (rst)
    bus.arvalid |-> !rd_pending);

endmodule

// File: lsu_top.sv
`timescale 1ns/100ps

module lsu_top #(
  parameter int mem_words  = 256,
  parameter int rd_latency = 2
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  rv_pkg::mem_op_e                in_op,
  input  rv_pkg::mem_size_e              in_size,
  input  logic                           in_load_signed,
  input  logic [rv_pkg::xlen-1:0]        in_addr,
  input  logic [rv_pkg::xlen-1:0]        in_store_data,
  input  logic [rv_pkg::xlen-1:0]        in_src2,
  input  logic [rv_pkg::xlen-1:0]        in_pc,
  input  logic [4:0]                     in_rd,
  input  logic                           in_reg_we,
  input  logic                           in_csr_we,
  input  rv_pkg::wd_sel_e                in_wd_sel,
  input  rv_pkg::csr_wd_sel_e            in_csr_wd_sel,
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [rv_pkg::xlen-1:0]        out_wd,
  output logic [rv_pkg::xlen-1:0]        out_csr_wd,
  output logic [rv_pkg::xlen-1:0]        out_pc,
  output logic [4:0]                     out_rd,
  output logic                           out_reg_we,
  output logic                           out_csr_we,
  output logic                           out_access_fault
);
  import rv_pkg::*;

  lsu_req_t         req;
  lsu_wb_t          wb;
  logic [xlen-1:0]  st_data;
  logic [3:0]       st_strb;
  logic [xlen-1:0]  ld_value;
  mem_size_e        cap_size;
  logic [1:0]       cap_addr_lo;
  logic             cap_load_signed;
  logic [xlen-1:0]  cap_store_data;
  logic [xlen-1:0]  rdata_q;

  assign req.op          = in_op;
  assign req.size        = in_size;
  assign req.load_signed = in_load_signed;
  assign req.addr        = in_addr;
  assign req.store_data  = in_store_data;
  assign req.src2        = in_src2;
  assign req.pc          = in_pc;
  assign req.rd          = in_rd;
  assign req.reg_we      = in_reg_we;
  assign req.csr_we      = in_csr_we;
  assign req.wd_sel      = in_wd_sel;
  assign req.csr_wd_sel  = in_csr_wd_sel;

  assign out_wd           = wb.wd;
  assign out_csr_wd       = wb.csr_wd;
  assign out_pc           = wb.pc;
  assign out_rd           = wb.rd;
  assign out_reg_we       = wb.reg_we;
  assign out_csr_we       = wb.csr_we;
  assign out_access_fault = wb.access_fault;

  axi_lite_if u_axi ();

  lsu_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .req             (req),
    .req_valid       (in_valid),
    .req_ready       (in_ready),
    .wb              (wb),
    .wb_valid        (out_valid),
    .wb_ready        (out_ready),
    .axi             (u_axi.master),
    .st_data         (st_data),
    .st_strb         (st_strb),
    .ld_value        (ld_value),
    .cap_size        (cap_size),
    .cap_addr_lo     (cap_addr_lo),
    .cap_load_signed (cap_load_signed),
    .cap_store_data  (cap_store_data),
    .rdata_q         (rdata_q)
  );

  mem_align u_align (
    .size        (cap_size),
    .addr_lo     (cap_addr_lo),
    .load_signed (cap_load_signed),
    .store_data  (cap_store_data),
    .rdata       (rdata_q),
    .wdata       (st_data),
    .wstrb       (st_strb),
    .load_value  (ld_value)
  );

  axi_lite_ram #(
    .mem_words  (mem_words),
    .rd_latency (rd_latency)
  ) u_ram (
    .clk (clk),
    .rst (rst),
    .bus (u_axi.slave)
  );

endmodule

// File: tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu;
  import rv_pkg::*;

  localparam int mem_words  = 256;
  localparam int rd_latency = 2;

  localparam logic [xlen-1:0] top_addr = (mem_words - 1) * 4;
  localparam logic [xlen-1:0] oor_addr = mem_words * 4;

  typedef struct {
    mem_op_e          op;
    mem_size_e        size;
    logic             sgn;
    logic [xlen-1:0]  addr;
    logic [xlen-1:0]  store_data;
    logic [xlen-1:0]  src2;
    logic [xlen-1:0]  pc;
    logic [4:0]       rd;
    logic             reg_we;
    logic             csr_we;
    wd_sel_e          wd_sel;
    csr_wd_sel_e      csr_sel;
    logic             fault;
  } entry_t;

  logic             clk;
  logic             rst;
  logic             in_valid;
  logic             in_ready;
  mem_op_e          in_op;
  mem_size_e        in_size;
  logic             in_load_signed;
  logic [xlen-1:0]  in_addr;
  logic [xlen-1:0]  in_store_data;
  logic [xlen-1:0]  in_src2;
  logic [xlen-1:0]  in_pc;
  logic [4:0]       in_rd;
  logic             in_reg_we;
  logic             in_csr_we;
  wd_sel_e          in_wd_sel;
  csr_wd_sel_e      in_csr_wd_sel;
  logic             out_valid;
  logic             out_ready;
  logic [xlen-1:0]  out_wd;
  logic [xlen-1:0]  out_csr_wd;
  logic [xlen-1:0]  out_pc;
  logic [4:0]       out_rd;
  logic             out_reg_we;
  logic             out_csr_we;
  logic             out_access_fault;

  entry_t      table_q[$];
  logic [7:0]  shadow [mem_words*4];
  int          cycle_cnt = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_results = 0;
  bit          table_built = 1'b0;

  lsu_top #(
    .mem_words  (mem_words),
    .rd_latency (rd_latency)
  ) dut0 (
    .clk              (clk),
    .rst              (rst),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .in_op            (in_op),
    .in_size          (in_size),
    .in_load_signed   (in_load_signed),
    .in_addr          (in_addr),
    .in_store_data    (in_store_data),
    .in_src2          (in_src2),
    .in_pc            (in_pc),
    .in_rd            (in_rd),
    .in_reg_we        (in_reg_we),
    .in_csr_we        (in_csr_we),
    .in_wd_sel        (in_wd_sel),
    .in_csr_wd_sel    (in_csr_wd_sel),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_wd           (out_wd),
    .out_csr_wd       (out_csr_wd),
    .out_pc           (out_pc),
    .out_rd           (out_rd),
    .out_reg_we       (out_reg_we),
    .out_csr_we       (out_csr_we),
    .out_access_fault (out_access_fault)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Results that leave the DUT, counted at the output handshake.
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) n_results <= n_results + 1;
  end

  // **************************************************
  // Compare tasks
  // **************************************************

  task automatic check_word(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_wb(input lsu_wb_t got, input lsu_wb_t exp);
    check_word("out_wd", got.wd, exp.wd);
    check_word("out_csr_wd", got.csr_wd, exp.csr_wd);
    check_word("out_pc", got.pc, exp.pc);
    check_word("out_rd", 32'(got.rd), 32'(exp.rd));
    check_flag("out_reg_we", got.reg_we, exp.reg_we);
    check_flag("out_csr_we", got.csr_we, exp.csr_we);
    check_flag("out_access_fault", got.access_fault, exp.access_fault);
  endtask

  function automatic lsu_wb_t read_wb();
    lsu_wb_t w;
    w.wd           = out_wd;
    w.csr_wd       = out_csr_wd;
    w.rd           = out_rd;
    w.reg_we       = out_reg_we;
    w.csr_we       = out_csr_we;
    w.pc           = out_pc;
    w.access_fault = out_access_fault;
    return w;
  endfunction

  // **************************************************
  // Reference model
  // **************************************************

  // A faulting load reads zero, which extends to zero.
  function automatic logic [xlen-1:0] load_model(input entry_t e);
    int a;
    a = int'(e.addr);
    if (e.fault) return '0;
    case (e.size)
      size_byte: return {{24{e.sgn & shadow[a][7]}}, shadow[a]};
      size_half: return {{16{e.sgn & shadow[a+1][7]}}, shadow[a+1], shadow[a]};
      default:   return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
    endcase
  endfunction

  function automatic lsu_wb_t expected_wb(input entry_t e);
    lsu_wb_t w;
    case (e.wd_sel)
      wd_alu:      w.wd = e.addr;
      wd_mem:      w.wd = load_model(e);
      wd_pc_plus4: w.wd = e.pc + 32'd4;
      default:     w.wd = e.src2;
    endcase
    w.csr_wd       = (e.csr_sel == csr_wd_pc) ? e.pc : e.addr;
    w.rd           = e.rd;
    w.reg_we       = e.reg_we && !e.fault;
    w.csr_we       = e.csr_we && !e.fault;
    w.pc           = e.pc;
    w.access_fault = e.fault;
    return w;
  endfunction

  function automatic int expected_cycles(input mem_op_e op);
    case (op)
      mem_load:  return rd_latency + 3;
      mem_store: return 4;
      default:   return 2;
    endcase
  endfunction

  task automatic update_shadow(input entry_t e);
    int a;
    a = int'(e.addr);
    if (e.op != mem_store || e.fault) return;
    case (e.size)
      size_byte: shadow[a] = e.store_data[7:0];
      size_half: begin
        shadow[a]   = e.store_data[7:0];
        shadow[a+1] = e.store_data[15:8];
      end
      default: begin
        for (int i = 0; i < 4; i++) shadow[a+i] = e.store_data[8*i +: 8];
      end
    endcase
  endtask

  // **************************************************
  // Stimulus table
  // **************************************************

  task automatic add_entry(input mem_op_e op, input mem_size_e size, input logic sgn,
                           input logic [xlen-1:0] addr, input wd_sel_e wd_sel,
                           input csr_wd_sel_e csr_sel, input logic fault);
    entry_t e;
    e.op         = op;
    e.size       = size;
    e.sgn        = sgn;
    e.addr       = addr;
    e.store_data = $urandom;
    e.src2       = $urandom;
    e.pc         = 32'h0000_1000 + 32'(4 * table_q.size());
    e.rd         = 5'(table_q.size() + 1);
    // Faulting entries ask for both writes so that the clearing shows.
    e.reg_we     = (op != mem_store) || fault;
    e.csr_we     = (op == mem_none) || fault;
    e.wd_sel     = wd_sel;
    e.csr_sel    = csr_sel;
    e.fault      = fault;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    add_entry(mem_store, size_word, 1'b0, 32'h000, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_word, 1'b0, 32'h000, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_store, size_word, 1'b0, 32'h004, wd_pc_plus4, csr_wd_pc, 1'b0);
    add_entry(mem_store, size_word, 1'b0, 32'h008, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_store, size_word, 1'b0, 32'h00c, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_store, size_byte, 1'b0, 32'h005, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_store, size_byte, 1'b0, 32'h007, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_store, size_byte, 1'b0, 32'h00c, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_store, size_byte, 1'b0, 32'h00e, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_word, 1'b0, 32'h004, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_word, 1'b0, 32'h00c, wd_mem, csr_wd_pc, 1'b0);
    add_entry(mem_load,  size_byte, 1'b1, 32'h004, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_byte, 1'b0, 32'h005, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_byte, 1'b1, 32'h006, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_byte, 1'b0, 32'h007, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_byte, 1'b1, 32'h00e, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_store, size_half, 1'b0, 32'h00a, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_store, size_half, 1'b0, 32'h000, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_word, 1'b0, 32'h008, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_half, 1'b1, 32'h008, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_half, 1'b0, 32'h00a, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_half, 1'b1, 32'h00a, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_none,  size_word, 1'b0, 32'h1234_5678, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_none,  size_word, 1'b0, 32'h0bad_f00d, wd_pc_plus4, csr_wd_pc, 1'b0);
    add_entry(mem_none,  size_word, 1'b0, 32'hcafe_0001, wd_src2, csr_wd_alu, 1'b0);
    add_entry(mem_none,  size_word, 1'b0, 32'h7fff_fffc, wd_alu, csr_wd_pc, 1'b0);
    // Word index mem_words aliases word 0 in the RAM decode.
    add_entry(mem_store, size_word, 1'b0, oor_addr, wd_alu, csr_wd_alu, 1'b1);
    add_entry(mem_load,  size_word, 1'b0, 32'h000, wd_mem, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_word, 1'b0, oor_addr + 32'h40, wd_mem, csr_wd_alu, 1'b1);
    add_entry(mem_load,  size_byte, 1'b1, oor_addr + 32'h81, wd_mem, csr_wd_pc, 1'b1);
    add_entry(mem_store, size_word, 1'b0, top_addr, wd_alu, csr_wd_alu, 1'b0);
    add_entry(mem_load,  size_word, 1'b0, top_addr, wd_mem, csr_wd_alu, 1'b0);
  endtask

  // **************************************************
  // Apply one entry and check its result
  // **************************************************

  task automatic apply_entry(input entry_t e);
    lsu_wb_t exp;
    int      acc_cyc;
    int      stall;
    exp   = expected_wb(e);
    stall = $urandom % 6;
    @(posedge clk);
    #1;
    in_valid       = 1'b1;
    in_op          = e.op;
    in_size        = e.size;
    in_load_signed = e.sgn;
    in_addr        = e.addr;
    in_store_data  = e.store_data;
    in_src2        = e.src2;
    in_pc          = e.pc;
    in_rd          = e.rd;
    in_reg_we      = e.reg_we;
    in_csr_we      = e.csr_we;
    in_wd_sel      = e.wd_sel;
    in_csr_wd_sel  = e.csr_sel;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    acc_cyc = cycle_cnt;
    @(posedge clk);
    #1;
    in_valid  = 1'b0;
    out_ready = (stall == 0);
    @(negedge clk);
    while (!out_valid) begin
      check_flag("in_ready", in_ready, 1'b0);
      @(negedge clk);
    end
    // The count includes both the accepting edge and the first edge with out_valid.
    check_cycles("cycles to out_valid", cycle_cnt - acc_cyc + 1, expected_cycles(e.op));
    check_wb(read_wb(), exp);
    // out_ready rises in the last stall cycle, so the result leaves on the edge after it.
    for (int j = 1; j <= stall; j++) begin
      @(posedge clk);
      #1;
      if (j == stall) out_ready = 1'b1;
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b1);
      check_flag("in_ready", in_ready, 1'b0);
      check_wb(read_wb(), exp);
    end
    @(posedge clk);
    #1;
    out_ready = 1'b0;
    @(negedge clk);
    check_flag("out_valid", out_valid, 1'b0);
    update_shadow(e);
  endtask

  initial begin
    void'($urandom(32'hd930));
    clk            = 1'b0;
    rst            = 1'b1;
    in_valid       = 1'b0;
    in_op          = mem_none;
    in_size        = size_word;
    in_load_signed = 1'b0;
    in_addr        = '0;
    in_store_data  = '0;
    in_src2        = '0;
    in_pc          = '0;
    in_rd          = '0;
    in_reg_we      = 1'b0;
    in_csr_we      = 1'b0;
    in_wd_sel      = wd_alu;
    in_csr_wd_sel  = csr_wd_alu;
    out_ready      = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);
    foreach (table_q[i]) apply_entry(table_q[i]);
    check_cycles("result count", n_results, table_q.size());
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    int limit_ns;
    wait (table_built);
    limit_ns = (table_q.size() * (rd_latency + 12) + 50) * 10;
    #(limit_ns);
    $display("Watchdog expired after %0d ns before the table was finished", limit_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: files.f
rv_pkg.sv
axi_pkg.sv
axi_lite_if.sv
mem_align.sv
lsu_ctrl.sv
axi_lite_ram.sv
lsu_top.sv
tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - rv_pkg.sv
  - axi_pkg.sv
  - axi_lite_if.sv
  - mem_align.sv
  - lsu_ctrl.sv
  - axi_lite_ram.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu.sv
